//--- include/memSubsys_consts.svh
`ifndef MEM_SUBSYS_CONSTS_SVH
`define MEM_SUBSYS_CONSTS_SVH

// bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// ram depth in 32-bit words
`define MEM_WORDS 1024

// MIPS primary opcodes, loads then stores
`define OPC_LB  6'd32
`define OPC_LH  6'd33
`define OPC_LW  6'd35
`define OPC_LBU 6'd36
`define OPC_LHU 6'd37
`define OPC_SB  6'd40
`define OPC_SH  6'd41
`define OPC_SW  6'd43

`endif

//--- design/mipsIsaPkg.sv
`include "memSubsys_consts.svh"

package mipsIsaPkg;

    // one code per memory instruction kind
    // 9 kinds so four bits are needed
    typedef enum logic [3:0] {
        MEM_INV,
        MEM_LB,
        MEM_LH,
        MEM_LW,
        MEM_LBU,
        MEM_LHU,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } memOpT;

    // raw opcode to memory op, anything else is invalid
    function automatic memOpT decodeOp(input logic [5:0] opcode);
        case (opcode)
            `OPC_LB:  return MEM_LB;
            `OPC_LH:  return MEM_LH;
            `OPC_LW:  return MEM_LW;
            `OPC_LBU: return MEM_LBU;
            `OPC_LHU: return MEM_LHU;
            `OPC_SB:  return MEM_SB;
            `OPC_SH:  return MEM_SH;
            `OPC_SW:  return MEM_SW;
            default:  return MEM_INV;
        endcase
    endfunction

endpackage

//--- design/axiLitePkg.sv
package axiLitePkg;

    // bresp / rresp encoding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axiRespT;

    // which master owns the slave
    typedef enum logic [1:0] {
        GNT_NONE  = 2'd0,
        GNT_DATA  = 2'd1,
        GNT_FETCH = 2'd2
    } grantT;

endpackage

//--- design/loadAlign.sv
`timescale 1ns/100ps
`include "memSubsys_consts.svh"

module loadAlign import mipsIsaPkg::*; (
    input  memOpT                   op,
    input  logic [1:0]              byteSel,  // low address bits
    input  logic [`DATA_WIDTH-1:0]  memWord,  // aligned word from ram
    output logic [`DATA_WIDTH-1:0]  loadData
);

    logic [7:0]  byteField;
    logic [15:0] halfField;

    // lane 0 is bits 7:0
    assign byteField = memWord[8*byteSel +: 8];
    // upper half when byteSel[1] set, byteSel[0] ignored
    assign halfField = memWord[16*byteSel[1] +: 16];

    always_comb begin
        case (op)
            MEM_LW:  loadData = memWord;
            MEM_LB:  loadData = {{24{byteField[7]}}, byteField};   // sign extend
            MEM_LBU: loadData = {24'h000000, byteField};           // zero extend
            MEM_LH:  loadData = {{16{halfField[15]}}, halfField};
            MEM_LHU: loadData = {16'h0000, halfField};
            default: loadData = '0;  // stores, invalid
        endcase
    end

endmodule

//--- design/dataPort.sv
`timescale 1ns/100ps
`include "memSubsys_consts.svh"

module dataPort import mipsIsaPkg::*, axiLitePkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    // core side
    input  logic                        dReq,
    input  logic [5:0]                  dOp,
    input  logic [`ADDR_WIDTH-1:0]      dAddr,
    input  logic [`DATA_WIDTH-1:0]      dWdata,
    output logic                        dReady,
    output logic                        dDone,
    output logic [`DATA_WIDTH-1:0]      dRdata,
    output logic                        dErr,
    // axi-lite master
    output logic                        dmAwvalid,
    input  logic                        dmAwready,
    output logic [`ADDR_WIDTH-1:0]      dmAwaddr,
    output logic                        dmWvalid,
    input  logic                        dmWready,
    output logic [`DATA_WIDTH-1:0]      dmWdata,
    output logic [`DATA_WIDTH/8-1:0]    dmWstrb,
    input  logic                        dmBvalid,
    output logic                        dmBready,
    input  axiRespT                     dmBresp,
    output logic                        dmArvalid,
    input  logic                        dmArready,
    output logic [`ADDR_WIDTH-1:0]      dmAraddr,
    input  logic                        dmRvalid,
    output logic                        dmRready,
    input  logic [`DATA_WIDTH-1:0]      dmRdata,
    input  axiRespT                     dmRresp
);

    typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ, ST_DONE} stateT;

    stateT                      state;
    memOpT                      reqOp;       // decoded from dOp, same cycle
    memOpT                      opQ;
    logic [`ADDR_WIDTH-1:0]     addrQ;
    logic [`DATA_WIDTH-1:0]     laneData;
    logic [`DATA_WIDTH/8-1:0]   laneStrb;
    logic [`DATA_WIDTH-1:0]     alignedData;
    logic                       accept;

    assign reqOp  = decodeOp(dOp);
    assign accept = dReq & dReady;

    // store data copied to every lane, strobe picks the target
    always_comb begin
        case (reqOp)
            MEM_SB: begin
                laneData = {4{dWdata[7:0]}};
                laneStrb = 4'b0001 << dAddr[1:0];
            end
            MEM_SH: begin
                laneData = {2{dWdata[15:0]}};
                laneStrb = dAddr[1] ? 4'b1100 : 4'b0011;  // dAddr[0] ignored
            end
            default: begin
                laneData = dWdata;
                laneStrb = 4'b1111;
            end
        endcase
    end

    loadAlign loadAlign_i (
        .op       (opQ),
        .byteSel  (addrQ[1:0]),
        .memWord  (dmRdata),
        .loadData (alignedData)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            dmAwvalid <= 1'b0;
            dmWvalid  <= 1'b0;
            dmArvalid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (accept) begin
                    if (reqOp == MEM_INV) begin
                        state <= ST_DONE;  // no bus traffic
                    end else if (reqOp inside {MEM_SB, MEM_SH, MEM_SW}) begin
                        state     <= ST_WRITE;
                        dmAwvalid <= 1'b1;  // aw and w raised together
                        dmWvalid  <= 1'b1;
                    end else begin
                        state     <= ST_READ;
                        dmArvalid <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (dmAwready) dmAwvalid <= 1'b0;  // each drops on its own
                    if (dmWready) dmWvalid <= 1'b0;
                    if (dmBvalid) state <= ST_DONE;    // bready high here
                end
                ST_READ: begin
                    if (dmArready) dmArvalid <= 1'b0;
                    if (dmRvalid) state <= ST_DONE;
                end
                default: state <= ST_IDLE;  // done pulse
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            opQ     <= reqOp;
            addrQ   <= dAddr;
            dmWdata <= laneData;
            dmWstrb <= laneStrb;
            dRdata  <= '0;
            dErr    <= (reqOp == MEM_INV);
        end
        if (dmBvalid && dmBready) dErr <= (dmBresp != RESP_OKAY);
        if (dmRvalid && dmRready) begin
            dErr   <= (dmRresp != RESP_OKAY);
            dRdata <= (dmRresp == RESP_OKAY) ? alignedData : '0;  // zero on error
        end
    end

    assign dmAwaddr = {addrQ[`ADDR_WIDTH-1:2], 2'b00};  // word aligned
    assign dmAraddr = {addrQ[`ADDR_WIDTH-1:2], 2'b00};
    assign dmBready = (state == ST_WRITE);
    assign dmRready = (state == ST_READ);
    assign dReady   = (state == ST_IDLE);
    assign dDone    = (state == ST_DONE);

endmodule

//--- design/fetchPort.sv
`timescale 1ns/100ps
`include "memSubsys_consts.svh"

module fetchPort import axiLitePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // core side
    input  logic                    fReq,
    input  logic [`ADDR_WIDTH-1:0]  fAddr,
    output logic                    fReady,
    output logic                    fDone,
    output logic [`DATA_WIDTH-1:0]  fInstr,
    output logic                    fErr,
    // axi-lite read channels only
    output logic                    fmArvalid,
    input  logic                    fmArready,
    output logic [`ADDR_WIDTH-1:0]  fmAraddr,
    input  logic                    fmRvalid,
    output logic                    fmRready,
    input  logic [`DATA_WIDTH-1:0]  fmRdata,
    input  axiRespT                 fmRresp
);

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_DONE} stateT;

    stateT state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            fmArvalid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (fReq) begin  // fReady high in idle
                    state     <= ST_READ;
                    fmArvalid <= 1'b1;
                end
                ST_READ: begin
                    if (fmArready) fmArvalid <= 1'b0;
                    if (fmRvalid) state <= ST_DONE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fReq && fReady) fmAraddr <= {fAddr[`ADDR_WIDTH-1:2], 2'b00};  // word reads only
        if (fmRvalid && fmRready) begin
            fErr   <= (fmRresp != RESP_OKAY);
            fInstr <= fmRdata;  // ram already zeroes data on error
        end
    end

    assign fmRready = (state == ST_READ);
    assign fReady   = (state == ST_IDLE);
    assign fDone    = (state == ST_DONE);

endmodule

//--- design/axiLiteArbiter.sv
`timescale 1ns/100ps
`include "memSubsys_consts.svh"

module axiLiteArbiter import axiLitePkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    // data master
    input  logic                        dmAwvalid,
    output logic                        dmAwready,
    input  logic [`ADDR_WIDTH-1:0]      dmAwaddr,
    input  logic                        dmWvalid,
    output logic                        dmWready,
    input  logic [`DATA_WIDTH-1:0]      dmWdata,
    input  logic [`DATA_WIDTH/8-1:0]    dmWstrb,
    output logic                        dmBvalid,
    input  logic                        dmBready,
    output axiRespT                     dmBresp,
    input  logic                        dmArvalid,
    output logic                        dmArready,
    input  logic [`ADDR_WIDTH-1:0]      dmAraddr,
    output logic                        dmRvalid,
    input  logic                        dmRready,
    output logic [`DATA_WIDTH-1:0]      dmRdata,
    output axiRespT                     dmRresp,
    // fetch master, reads only
    input  logic                        fmArvalid,
    output logic                        fmArready,
    input  logic [`ADDR_WIDTH-1:0]      fmAraddr,
    output logic                        fmRvalid,
    input  logic                        fmRready,
    output logic [`DATA_WIDTH-1:0]      fmRdata,
    output axiRespT                     fmRresp,
    // toward the ram
    output logic                        sAwvalid,
    input  logic                        sAwready,
    output logic [`ADDR_WIDTH-1:0]      sAwaddr,
    output logic                        sWvalid,
    input  logic                        sWready,
    output logic [`DATA_WIDTH-1:0]      sWdata,
    output logic [`DATA_WIDTH/8-1:0]    sWstrb,
    input  logic                        sBvalid,
    output logic                        sBready,
    input  axiRespT                     sBresp,
    output logic                        sArvalid,
    input  logic                        sArready,
    output logic [`ADDR_WIDTH-1:0]      sAraddr,
    input  logic                        sRvalid,
    output logic                        sRready,
    input  logic [`DATA_WIDTH-1:0]      sRdata,
    input  axiRespT                     sRresp
);

    grantT grant;
    logic  lastData;   // data master had the last grant
    logic  dataWants;
    logic  txnEnd;     // last response beat of the owner
    logic  toData;
    logic  toFetch;

    assign dataWants = dmAwvalid | dmWvalid | dmArvalid;
    assign txnEnd    = (sRvalid & sRready) | (sBvalid & sBready);
    assign toData    = (grant == GNT_DATA);
    assign toFetch   = (grant == GNT_FETCH);

    always_ff @(posedge clk) begin
        if (rst) begin
            grant    <= GNT_NONE;
            lastData <= 1'b0;
        end else if (grant == GNT_NONE) begin
            // round robin, the other master wins a tie
            if (dataWants && (!fmArvalid || !lastData)) grant <= GNT_DATA;
            else if (fmArvalid) grant <= GNT_FETCH;
        end else if (txnEnd) begin
            lastData <= toData;
            grant    <= GNT_NONE;
        end
    end

    // write path belongs to the data master only
    assign sAwvalid  = toData & dmAwvalid;
    assign sAwaddr   = dmAwaddr;
    assign sWvalid   = toData & dmWvalid;
    assign sWdata    = dmWdata;
    assign sWstrb    = dmWstrb;
    assign sBready   = toData & dmBready;
    assign dmAwready = toData & sAwready;
    assign dmWready  = toData & sWready;
    assign dmBvalid  = toData & sBvalid;
    assign dmBresp   = sBresp;

    // read path muxed by grant, loser sees ready low
    assign sArvalid  = toData ? dmArvalid : (toFetch & fmArvalid);
    assign sAraddr   = toFetch ? fmAraddr : dmAraddr;
    assign sRready   = toData ? dmRready : (toFetch & fmRready);
    assign dmArready = toData & sArready;
    assign fmArready = toFetch & sArready;
    assign dmRvalid  = toData & sRvalid;
    assign fmRvalid  = toFetch & sRvalid;
    assign dmRdata   = sRdata;   // shared, qualified by valid
    assign fmRdata   = sRdata;
    assign dmRresp   = sRresp;
    assign fmRresp   = sRresp;

endmodule

//--- design/dataRam.sv
`timescale 1ns/100ps
`include "memSubsys_consts.svh"

module dataRam import axiLitePkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        sAwvalid,
    output logic                        sAwready,
    input  logic [`ADDR_WIDTH-1:0]      sAwaddr,
    input  logic                        sWvalid,
    output logic                        sWready,
    input  logic [`DATA_WIDTH-1:0]      sWdata,
    input  logic [`DATA_WIDTH/8-1:0]    sWstrb,
    output logic                        sBvalid,
    input  logic                        sBready,
    output axiRespT                     sBresp,
    input  logic                        sArvalid,
    output logic                        sArready,
    input  logic [`ADDR_WIDTH-1:0]      sAraddr,
    output logic                        sRvalid,
    input  logic                        sRready,
    output logic [`DATA_WIDTH-1:0]      sRdata,
    output axiRespT                     sRresp
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    logic [`DATA_WIDTH-1:0]     mem [`MEM_WORDS];
    logic                       awTaken, wTaken;  // one half of a write seen
    logic [`ADDR_WIDTH-1:0]     awAddrQ, wrAddr;
    logic [`DATA_WIDTH-1:0]     wDataQ, wrData;
    logic [`DATA_WIDTH/8-1:0]   wStrbQ, wrStrb;
    logic                       busy, awFire, wFire, arFire, wrGo;
    logic                       wrInRange, rdInRange;

    assign busy     = sRvalid | sBvalid;  // response pending, take nothing
    assign sAwready = !busy && !awTaken;
    assign sWready  = !busy && !wTaken;
    assign sArready = !busy && !awTaken && !wTaken;
    assign awFire   = sAwvalid & sAwready;
    assign wFire    = sWvalid & sWready;
    assign arFire   = sArvalid & sArready;

    // current beat or the held one
    assign wrAddr    = awTaken ? awAddrQ : sAwaddr;
    assign wrData    = wTaken ? wDataQ : sWdata;
    assign wrStrb    = wTaken ? wStrbQ : sWstrb;
    assign wrGo      = (awTaken | awFire) & (wTaken | wFire);
    assign wrInRange = (wrAddr[`ADDR_WIDTH-1:2] < `MEM_WORDS);
    assign rdInRange = (sAraddr[`ADDR_WIDTH-1:2] < `MEM_WORDS);

    always_ff @(posedge clk) begin
        if (rst) begin
            awTaken <= 1'b0;
            wTaken  <= 1'b0;
            sBvalid <= 1'b0;
            sRvalid <= 1'b0;
        end else begin
            if (wrGo) begin
                awTaken <= 1'b0;
                wTaken  <= 1'b0;
                sBvalid <= 1'b1;  // b the cycle after both halves
            end else begin
                if (awFire) awTaken <= 1'b1;
                if (wFire) wTaken <= 1'b1;
            end
            if (sBvalid && sBready) sBvalid <= 1'b0;
            if (arFire) sRvalid <= 1'b1;
            else if (sRready) sRvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (awFire) awAddrQ <= sAwaddr;
        if (wFire) begin
            wDataQ <= sWdata;
            wStrbQ <= sWstrb;
        end
        if (wrGo) begin
            sBresp <= wrInRange ? RESP_OKAY : RESP_SLVERR;
            for (int b = 0; b < `DATA_WIDTH/8; b++) begin
                if (wrInRange && wrStrb[b]) mem[wrAddr[IDX_W+1:2]][8*b +: 8] <= wrData[8*b +: 8];
            end
        end
        if (arFire) begin
            sRdata <= rdInRange ? mem[sAraddr[IDX_W+1:2]] : '0;  // zero data on error
            sRresp <= rdInRange ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

//--- design/memSubsystem.sv
`timescale 1ns/100ps
`include "memSubsys_consts.svh"

module memSubsystem import axiLitePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // data port, loads and stores
    input  logic                    dReq,
    input  logic [5:0]              dOp,
    input  logic [`ADDR_WIDTH-1:0]  dAddr,
    input  logic [`DATA_WIDTH-1:0]  dWdata,
    output logic                    dReady,
    output logic                    dDone,
    output logic [`DATA_WIDTH-1:0]  dRdata,
    output logic                    dErr,
    // fetch port
    input  logic                    fReq,
    input  logic [`ADDR_WIDTH-1:0]  fAddr,
    output logic                    fReady,
    output logic                    fDone,
    output logic [`DATA_WIDTH-1:0]  fInstr,
    output logic                    fErr
);

    // data master channels
    logic dmAwvalid, dmAwready, dmWvalid, dmWready, dmBvalid, dmBready;
    logic dmArvalid, dmArready, dmRvalid, dmRready;
    logic [`ADDR_WIDTH-1:0]     dmAwaddr, dmAraddr;
    logic [`DATA_WIDTH-1:0]     dmWdata, dmRdata;
    logic [`DATA_WIDTH/8-1:0]   dmWstrb;
    axiRespT                    dmBresp, dmRresp;

    // fetch master, read side
    logic fmArvalid, fmArready, fmRvalid, fmRready;
    logic [`ADDR_WIDTH-1:0]     fmAraddr;
    logic [`DATA_WIDTH-1:0]     fmRdata;
    axiRespT                    fmRresp;

    // arbiter to ram
    logic sAwvalid, sAwready, sWvalid, sWready, sBvalid, sBready;
    logic sArvalid, sArready, sRvalid, sRready;
    logic [`ADDR_WIDTH-1:0]     sAwaddr, sAraddr;
    logic [`DATA_WIDTH-1:0]     sWdata, sRdata;
    logic [`DATA_WIDTH/8-1:0]   sWstrb;
    axiRespT                    sBresp, sRresp;

    // names line up across the tree
    dataPort       dataPort_i (.*);
    fetchPort      fetchPort_i (.*);
    axiLiteArbiter axiLiteArbiter_i (.*);
    dataRam        dataRam_i (.*);

endmodule

//--- testbench/memSubsystemChecker.sv
`timescale 1ns/100ps
`include "memSubsys_consts.svh"

module memSubsystemChecker import mipsIsaPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dReq,
    input  logic [5:0]              dOp,
    input  logic [`ADDR_WIDTH-1:0]  dAddr,
    input  logic [`DATA_WIDTH-1:0]  dWdata,
    input  logic                    dReady,
    input  logic                    dDone,
    input  logic [`DATA_WIDTH-1:0]  dRdata,
    input  logic                    dErr,
    input  logic [`DATA_WIDTH-1:0]  expData,  // presented with the request
    input  logic                    expErr,
    input  logic                    fReq,
    input  logic [`ADDR_WIDTH-1:0]  fAddr,
    input  logic                    fReady,
    input  logic                    fDone,
    input  logic [`DATA_WIDTH-1:0]  fInstr,
    input  logic                    fErr,
    output int                      errCount,
    output int                      dataChecks,
    output int                      fetchChecks
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    logic [`DATA_WIDTH-1:0] shadow [`MEM_WORDS];  // what the ram should hold
    logic [5:0]             opQ;
    logic [`ADDR_WIDTH-1:0] addrQ;
    logic [`DATA_WIDTH-1:0] wdataQ;
    logic [`DATA_WIDTH-1:0] expDataQ;
    logic                   expErrQ;
    logic [`ADDR_WIDTH-1:0] fAddrQ;
    logic [`DATA_WIDTH-1:0] fExpInstr;
    logic                   fInRange;
    logic                   dInRange;
    logic                   dBusy;  // data request open until its done
    logic                   fBusy;

    always @(posedge clk) begin
        if (rst) begin
            errCount    = 0;
            dataChecks  = 0;
            fetchChecks = 0;
            dBusy       = 1'b0;
            fBusy       = 1'b0;
        end else begin
            // ready stays low while a request is open
            if (dBusy && dReady) begin
                errCount++;
                $display("ERR %0t dReady high while a data request is open", $time);
            end
            if (fBusy && fReady) begin
                errCount++;
                $display("ERR %0t fReady high while a fetch request is open", $time);
            end
            // one done pulse per request
            if (dDone && !dBusy) begin
                errCount++;
                $display("ERR %0t dDone with no open data request", $time);
            end
            if (fDone && !fBusy) begin
                errCount++;
                $display("ERR %0t fDone with no open fetch request", $time);
            end
            if (dReq && dReady) begin  // request taken
                opQ      = dOp;
                addrQ    = dAddr;
                wdataQ   = dWdata;
                expDataQ = expData;
                expErrQ  = expErr;
                dBusy    = 1'b1;
            end
            if (fReq && fReady) begin
                fAddrQ = fAddr;
                fBusy  = 1'b1;
            end
            // fetch first since a store finishing now is not visible yet
            if (fDone) begin
                fetchChecks++;
                fBusy     = 1'b0;
                fInRange  = ({2'b00, fAddrQ[`ADDR_WIDTH-1:2]} < 32'(`MEM_WORDS));
                fExpInstr = fInRange ? shadow[fAddrQ[IDX_W+1:2]] : '0;
                if (fInstr !== fExpInstr || fErr !== !fInRange) begin
                    errCount++;
                    $display("ERR %0t fetch addr %h: got %h err %0b, expected %h err %0b",
                             $time, fAddrQ, fInstr, fErr, fExpInstr, !fInRange);
                end
            end
            if (dDone) begin
                dataChecks++;
                dBusy = 1'b0;
                if (dRdata !== expDataQ || dErr !== expErrQ) begin
                    errCount++;
                    $display("ERR %0t data op %0d addr %h: got %h err %0b, expected %h err %0b",
                             $time, opQ, addrQ, dRdata, dErr, expDataQ, expErrQ);
                end
                dInRange = ({2'b00, addrQ[`ADDR_WIDTH-1:2]} < 32'(`MEM_WORDS));
                if (dInRange) begin
                    case (opQ)
                        `OPC_SB: shadow[addrQ[IDX_W+1:2]][8*addrQ[1:0] +: 8] = wdataQ[7:0];
                        `OPC_SH: shadow[addrQ[IDX_W+1:2]][16*addrQ[1] +: 16] = wdataQ[15:0];
                        `OPC_SW: shadow[addrQ[IDX_W+1:2]] = wdataQ;
                        default: ;  // loads and bad opcodes leave memory alone
                    endcase
                end
            end
        end
    end

endmodule

//--- testbench/memSubsystem_tb.sv
`timescale 1ns/100ps
`include "memSubsys_consts.svh"

module memSubsystem_tb;

    localparam int TIMEOUT   = 200;  // cycles allowed per wait
    localparam int NUM_FETCH = 24;

    // one row of the data stimulus table
    typedef struct {
        logic [5:0]             op;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wdata;
        logic [`DATA_WIDTH-1:0] expData;
        logic                   expErr;
    } stimT;

    logic                   clk;
    logic                   rst;
    logic                   dReq;
    logic [5:0]             dOp;
    logic [`ADDR_WIDTH-1:0] dAddr;
    logic [`DATA_WIDTH-1:0] dWdata;
    logic                   dReady;
    logic                   dDone;
    logic [`DATA_WIDTH-1:0] dRdata;
    logic                   dErr;
    logic                   fReq;
    logic [`ADDR_WIDTH-1:0] fAddr;
    logic                   fReady;
    logic                   fDone;
    logic [`DATA_WIDTH-1:0] fInstr;
    logic                   fErr;
    logic [`DATA_WIDTH-1:0] expData;  // expected result held with the request
    logic                   expErr;
    int                     errCount;
    int                     dataChecks;
    int                     fetchChecks;
    int                     stallCount;
    stimT                   stimTable[$];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    memSubsystem memSubsystem_i (.*);

    memSubsystemChecker memSubsystemChecker_i (.*);

    task automatic endRun();
        $display("data checks %0d, fetch checks %0d, errors %0d, stalls %0d",
                 dataChecks, fetchChecks, errCount, stallCount);
        if (errCount == 0 && stallCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic reportStall(input string what);
        $display("Timeout at %0t: %s", $time, what);
        stallCount++;
    endtask

    task automatic addEntry(input logic [5:0] op, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [31:0] expD,
                            input logic expE);
        stimT s;
        s.op      = op;
        s.addr    = addr;
        s.wdata   = wdata;
        s.expData = expD;
        s.expErr  = expE;
        stimTable.push_back(s);
    endtask

    task automatic buildTable();
        // whole words with top bits set and clear
        addEntry(`OPC_SW,  32'h000, 32'h1122_3344, 32'h0000_0000, 1'b0);
        addEntry(`OPC_SW,  32'h004, 32'h8899_aabb, 32'h0000_0000, 1'b0);
        addEntry(`OPC_SW,  32'h008, 32'h7f80_ff01, 32'h0000_0000, 1'b0);
        addEntry(`OPC_SW,  32'h00c, 32'ha5a5_a5a5, 32'h0000_0000, 1'b0);
        addEntry(`OPC_SW,  32'h010, 32'h0123_4567, 32'h0000_0000, 1'b0);
        addEntry(`OPC_LW,  32'h000, 32'h0,         32'h1122_3344, 1'b0);
        addEntry(`OPC_LW,  32'h004, 32'h0,         32'h8899_aabb, 1'b0);
        // byte stores to one lane each
        addEntry(`OPC_SB,  32'h00d, 32'h0000_00c3, 32'h0000_0000, 1'b0);
        addEntry(`OPC_SB,  32'h00f, 32'h1234_563c, 32'h0000_0000, 1'b0);
        addEntry(`OPC_LW,  32'h00c, 32'h0,         32'h3ca5_c3a5, 1'b0);
        addEntry(`OPC_SB,  32'h00c, 32'hffff_ff00, 32'h0000_0000, 1'b0);
        addEntry(`OPC_SB,  32'h00e, 32'h0000_0077, 32'h0000_0000, 1'b0);
        addEntry(`OPC_LW,  32'h00c, 32'h0,         32'h3c77_c300, 1'b0);
        // halfword stores upper then lower
        addEntry(`OPC_SH,  32'h012, 32'hdead_beef, 32'h0000_0000, 1'b0);
        addEntry(`OPC_LW,  32'h010, 32'h0,         32'hbeef_4567, 1'b0);
        addEntry(`OPC_SH,  32'h010, 32'hffff_1357, 32'h0000_0000, 1'b0);
        addEntry(`OPC_LW,  32'h010, 32'h0,         32'hbeef_1357, 1'b0);
        addEntry(`OPC_LW,  32'h008, 32'h0,         32'h7f80_ff01, 1'b0);  // untouched
        // sign and zero extension per lane
        addEntry(`OPC_LB,  32'h004, 32'h0,         32'hffff_ffbb, 1'b0);
        addEntry(`OPC_LB,  32'h005, 32'h0,         32'hffff_ffaa, 1'b0);
        addEntry(`OPC_LB,  32'h006, 32'h0,         32'hffff_ff99, 1'b0);
        addEntry(`OPC_LB,  32'h007, 32'h0,         32'hffff_ff88, 1'b0);
        addEntry(`OPC_LBU, 32'h004, 32'h0,         32'h0000_00bb, 1'b0);
        addEntry(`OPC_LBU, 32'h005, 32'h0,         32'h0000_00aa, 1'b0);
        addEntry(`OPC_LBU, 32'h007, 32'h0,         32'h0000_0088, 1'b0);
        addEntry(`OPC_LB,  32'h000, 32'h0,         32'h0000_0044, 1'b0);
        addEntry(`OPC_LB,  32'h001, 32'h0,         32'h0000_0033, 1'b0);
        addEntry(`OPC_LB,  32'h002, 32'h0,         32'h0000_0022, 1'b0);
        addEntry(`OPC_LB,  32'h003, 32'h0,         32'h0000_0011, 1'b0);
        addEntry(`OPC_LBU, 32'h002, 32'h0,         32'h0000_0022, 1'b0);
        addEntry(`OPC_LBU, 32'h003, 32'h0,         32'h0000_0011, 1'b0);
        addEntry(`OPC_LB,  32'h009, 32'h0,         32'hffff_ffff, 1'b0);
        addEntry(`OPC_LBU, 32'h00a, 32'h0,         32'h0000_0080, 1'b0);
        addEntry(`OPC_LH,  32'h004, 32'h0,         32'hffff_aabb, 1'b0);
        addEntry(`OPC_LH,  32'h006, 32'h0,         32'hffff_8899, 1'b0);
        addEntry(`OPC_LHU, 32'h006, 32'h0,         32'h0000_8899, 1'b0);
        addEntry(`OPC_LH,  32'h000, 32'h0,         32'h0000_3344, 1'b0);
        addEntry(`OPC_LH,  32'h002, 32'h0,         32'h0000_1122, 1'b0);
        addEntry(`OPC_LHU, 32'h000, 32'h0,         32'h0000_3344, 1'b0);
        addEntry(`OPC_LHU, 32'h008, 32'h0,         32'h0000_ff01, 1'b0);
        addEntry(`OPC_LH,  32'h00a, 32'h0,         32'h0000_7f80, 1'b0);
        // out of range and undefined opcodes
        addEntry(`OPC_LW,  32'h1000, 32'h0,        32'h0000_0000, 1'b1);
        addEntry(`OPC_SW,  32'h1000, 32'h55aa_55aa, 32'h0000_0000, 1'b1);
        addEntry(6'd34,    32'h000, 32'hffff_ffff, 32'h0000_0000, 1'b1);
        addEntry(6'd0,     32'h004, 32'hffff_ffff, 32'h0000_0000, 1'b1);
        addEntry(`OPC_LW,  32'h000, 32'h0,         32'h1122_3344, 1'b0);  // unchanged
        addEntry(`OPC_LW,  32'h004, 32'h0,         32'h8899_aabb, 1'b0);
    endtask

    task automatic sendData(input stimT s);
        int cycles;
        if (stallCount != 0) return;  // a port already hung
        cycles = 0;
        while (!dReady && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!dReady) begin
            reportStall("data port stayed busy, dReady never rose");
            return;
        end
        dReq    = 1'b1;
        dOp     = s.op;
        dAddr   = s.addr;
        dWdata  = s.wdata;
        expData = s.expData;
        expErr  = s.expErr;
        @(posedge clk);  // taken on this edge
        #1;
        dReq   = 1'b0;
        cycles = 0;
        while (!dDone && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!dDone) begin
            reportStall("data request was taken but dDone never pulsed");
            return;
        end
        @(posedge clk);  // let the done cycle pass
        #1;
    endtask

    task automatic sendFetch(input logic [`ADDR_WIDTH-1:0] addr);
        int cycles;
        if (stallCount != 0) return;
        cycles = 0;
        while (!fReady && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!fReady) begin
            reportStall("fetch port stayed busy, fReady never rose");
            return;
        end
        fReq  = 1'b1;
        fAddr = addr;
        @(posedge clk);
        #1;
        fReq   = 1'b0;
        cycles = 0;
        while (!fDone && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!fDone) begin
            reportStall("fetch request was taken but fDone never pulsed");
            return;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic runFetches();
        int gap;
        logic [`ADDR_WIDTH-1:0] addr;
        for (int n = 0; n < NUM_FETCH; n++) begin
            addr = ($urandom % 5) * 4 + ($urandom % 4);  // words 0..4 with any low bits
            gap  = $urandom % 4;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            sendFetch(addr);
        end
    endtask

    initial begin
        void'($urandom(32'had12_3c0f));
        rst        = 1'b1;
        dReq       = 1'b0;
        dOp        = 6'd0;
        dAddr      = '0;
        dWdata     = '0;
        fReq       = 1'b0;
        fAddr      = '0;
        expData    = '0;
        expErr     = 1'b0;
        stallCount = 0;
        buildTable();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // data port on its own
        foreach (stimTable[i]) sendData(stimTable[i]);
        // same table again with fetches competing for the ram
        fork
            foreach (stimTable[i]) sendData(stimTable[i]);
            runFetches();
        join
        endRun();
    end

endmodule

//--- sources.f
+incdir+include
design/mipsIsaPkg.sv
design/axiLitePkg.sv
design/loadAlign.sv
design/dataPort.sv
design/fetchPort.sv
design/axiLiteArbiter.sv
design/dataRam.sv
design/memSubsystem.sv
testbench/memSubsystemChecker.sv
testbench/memSubsystem_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0 -Wno-fatal
TOP      := memSubsystem_tb
FILELIST := sources.f
OBJDIR   := obj_dir
PASS_MSG := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
